/* verilog/acc_config.svh */
`ifndef ACC_CONFIG_SVH
`define ACC_CONFIG_SVH

// Sample and sum widths
`define ACC_IN_WIDTH  16
`define ACC_OUT_WIDTH 24

// Arguments (range bins) per burst
`define ACC_N_ARGS    16

// Burst and group counters, also kg_count and nkg_count
`define ACC_CNT_WIDTH 16

`define ACC_WE_DELAY  2
`define ACC_BURST_GAP 2

`endif

/* verilog/acc_pkg.sv */
`include "acc_config.svh"

package acc_pkg;

    localparam int ARG_ADDR_WIDTH = $clog2(`ACC_N_ARGS);

    // Signed input sample
    typedef logic signed [`ACC_IN_WIDTH-1:0] sample_t;

    // Signed running sum, as stored in the line memory
    typedef logic signed [`ACC_OUT_WIDTH-1:0] acc_t;

    typedef logic [ARG_ADDR_WIDTH-1:0] arg_addr_t;

    // Burst index within a group, or group index within a frame
    typedef logic [`ACC_CNT_WIDTH-1:0] burst_cnt_t;

endpackage

/* verilog/delay_line.sv */
`timescale 1ns/10ps

module delay_line #(
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic in,
    output logic out
);

    logic [DEPTH-1:0] stages;

    // Stage 0 takes the input, every later stage takes its neighbour
    always_ff @(posedge clk) begin
        if (reset) begin
            stages <= '0;
        end else begin
            stages[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Exactly DEPTH cycles from in to out
    assign out = stages[DEPTH-1];

endmodule

/* verilog/line_memory.sv */
`timescale 1ns/10ps

`include "acc_config.svh"

module line_memory (
    input  logic              clk,
    input  logic              reset,
    input  logic              we_wr,
    input  acc_pkg::arg_addr_t rd_addr,
    input  acc_pkg::acc_t     wr_data,
    output acc_pkg::acc_t     mem_out
);

    localparam acc_pkg::arg_addr_t LAST_ADDR = acc_pkg::arg_addr_t'(`ACC_N_ARGS - 1);

    // One running sum per argument
    acc_pkg::acc_t mem [`ACC_N_ARGS];

    acc_pkg::arg_addr_t wr_addr;

    // Write address follows the write strobe; since we_wr is the read
    // strobe delayed, this lands on the same argument the read used
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr <= '0;
        end else if (!we_wr || wr_addr == LAST_ADDR) begin
            wr_addr <= '0;
        end else begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, always enabled
    // Burst gap keeps this from reading a word in the cycle it is written
    always_ff @(posedge clk) begin
        mem_out <= mem[rd_addr];
    end

endmodule

/* verilog/accum_sequencer.sv */
`timescale 1ns/10ps

`include "acc_config.svh"

module accum_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                coh_mode,
    input  acc_pkg::burst_cnt_t kg_count,
    input  acc_pkg::burst_cnt_t nkg_count,
    input  logic                we,
    input  logic                we_wr,
    output acc_pkg::arg_addr_t  rd_addr,
    output logic                load_sum,
    output logic                add_en,
    output logic                valid
);

    localparam acc_pkg::arg_addr_t LAST_ARG = acc_pkg::arg_addr_t'(`ACC_N_ARGS - 1);

    acc_pkg::burst_cnt_t kg_cntr;
    acc_pkg::burst_cnt_t nkg_cntr;
    logic                last_arg;
    logic                last_kg;
    logic                last_nkg;
    logic                frame_final;
    logic                frame_final_wr;

    assign last_arg = we && (rd_addr == LAST_ARG);
    assign last_kg  = kg_cntr == acc_pkg::burst_cnt_t'(kg_count - 1'b1);
    assign last_nkg = nkg_cntr == acc_pkg::burst_cnt_t'(nkg_count - 1'b1);

    // Argument read counter, runs only while the burst is on the input
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_addr <= '0;
        end else if (!we || last_arg) begin
            rd_addr <= '0;
        end else begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // Burst within a kg group
    always_ff @(posedge clk) begin
        if (reset) begin
            kg_cntr <= '0;
        end else if (last_arg) begin
            if (last_kg) begin
                kg_cntr <= '0;
            end else begin
                kg_cntr <= kg_cntr + 1'b1;
            end
        end
    end

    // Group within the frame, steps at the end of each group
    always_ff @(posedge clk) begin
        if (reset) begin
            nkg_cntr <= '0;
        end else if (last_arg && last_kg) begin
            if (last_nkg) begin
                nkg_cntr <= '0;
            end else begin
                nkg_cntr <= nkg_cntr + 1'b1;
            end
        end
    end

    // Sum control for the sample now on the input, used one cycle later
    // Coherent: restart each group, add every burst
    // Non-coherent: only the last burst of a group counts
    always_ff @(posedge clk) begin
        if (reset) begin
            load_sum <= 1'b0;
            add_en   <= 1'b0;
        end else if (coh_mode) begin
            load_sum <= kg_cntr == '0;
            add_en   <= 1'b1;
        end else begin
            load_sum <= last_kg && (nkg_cntr == '0);
            add_en   <= last_kg;
        end
    end

    assign frame_final = last_kg && last_nkg;

    // Frame-final flag travels alongside we to the write stage
    delay_line #(
        .DEPTH (`ACC_WE_DELAY)
    ) final_delay (
        .clk   (clk),
        .reset (reset),
        .in    (frame_final),
        .out   (frame_final_wr)
    );

    assign valid = coh_mode ? we_wr : (we_wr && frame_final_wr);

endmodule

/* verilog/accum_datapath.sv */
`timescale 1ns/10ps

module accum_datapath (
    input  logic             clk,
    input  logic             reset,
    input  acc_pkg::sample_t r_in,
    input  acc_pkg::acc_t    mem_out,
    input  logic             load_sum,
    input  logic             add_en,
    output acc_pkg::acc_t    sum
);

    acc_pkg::sample_t r_in_reg;
    acc_pkg::acc_t    sample_ext;

    // Sample waits one cycle for its memory word
    always_ff @(posedge clk) begin
        r_in_reg <= r_in;
    end

    // Signed cast widens with the sign bit
    assign sample_ext = acc_pkg::acc_t'(r_in_reg);

    // Load starts a new sum, add accumulates, otherwise the old word
    // goes back to memory untouched
    always_ff @(posedge clk) begin
        if (reset) begin
            sum <= '0;
        end else if (load_sum) begin
            sum <= sample_ext;
        end else if (add_en) begin
            sum <= sample_ext + mem_out;
        end else begin
            sum <= mem_out;
        end
    end

endmodule

/* verilog/arr_accum.sv */
`timescale 1ns/10ps

`include "acc_config.svh"

module arr_accum (
    input  logic                clk,
    input  logic                reset,
    input  logic                coh_mode,
    input  acc_pkg::burst_cnt_t kg_count,
    input  acc_pkg::burst_cnt_t nkg_count,
    input  logic                we,
    input  acc_pkg::sample_t    r_in,
    output acc_pkg::acc_t       r_out,
    output logic                valid
);

    logic               we_wr;
    logic               load_sum;
    logic               add_en;
    acc_pkg::arg_addr_t rd_addr;
    acc_pkg::acc_t      mem_out;
    acc_pkg::acc_t      sum;

    // we lined up with the sum register output
    delay_line #(
        .DEPTH (`ACC_WE_DELAY)
    ) we_delay (
        .clk   (clk),
        .reset (reset),
        .in    (we),
        .out   (we_wr)
    );

    accum_sequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .coh_mode  (coh_mode),
        .kg_count  (kg_count),
        .nkg_count (nkg_count),
        .we        (we),
        .we_wr     (we_wr),
        .rd_addr   (rd_addr),
        .load_sum  (load_sum),
        .add_en    (add_en),
        .valid     (valid)
    );

    accum_datapath datapath (
        .clk      (clk),
        .reset    (reset),
        .r_in     (r_in),
        .mem_out  (mem_out),
        .load_sum (load_sum),
        .add_en   (add_en),
        .sum      (sum)
    );

    // Sum is written back in the same cycle it is presented
    line_memory memory (
        .clk     (clk),
        .reset   (reset),
        .we_wr   (we_wr),
        .rd_addr (rd_addr),
        .wr_data (sum),
        .mem_out (mem_out)
    );

    assign r_out = sum;

endmodule

/* tb/tb_arr_accum.sv */
`timescale 1ns/10ps

`include "acc_config.svh"

module tb_arr_accum;

    localparam int N_ARGS     = `ACC_N_ARGS;
    localparam int N_RUNS     = 4;
    localparam int MAX_JITTER = 3;

    logic                clk;
    logic                reset;
    logic                coh_mode;
    acc_pkg::burst_cnt_t kg_count;
    acc_pkg::burst_cnt_t nkg_count;
    logic                we;
    acc_pkg::sample_t    r_in;
    acc_pkg::acc_t       r_out;
    logic                valid;

    // One entry per run: mode, bursts per group, groups per frame, frames
    int run_coh    [N_RUNS] = '{1, 0, 1, 0};
    int run_kg     [N_RUNS] = '{3, 3, 1, 1};
    int run_nkg    [N_RUNS] = '{2, 4, 1, 1};
    int run_frames [N_RUNS] = '{2, 2, 3, 3};

    // Reference sums, one per argument
    acc_pkg::acc_t model [N_ARGS];

    // Expected outputs in order, tagged with the cycle they must appear in
    longint        exp_cycle [$];
    acc_pkg::acc_t exp_val   [$];
    int            exp_arg   [$];

    longint cycle_no = 0;
    bit     armed    = 1'b0;

    arr_accum dut (
        .clk       (clk),
        .reset     (reset),
        .coh_mode  (coh_mode),
        .kg_count  (kg_count),
        .nkg_count (nkg_count),
        .we        (we),
        .r_in      (r_in),
        .r_out     (r_out),
        .valid     (valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
    end

    task automatic report_mismatch(string name, longint expected, longint actual);
        $display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("%s (at %0t ns)", what, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic int total_bursts();
        int total;
        total = 0;
        for (int r = 0; r < N_RUNS; r++) begin
            total += run_frames[r] * run_kg[r] * run_nkg[r];
        end
        return total;
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // Drives one burst and updates the model by the mode rules
    task automatic drive_burst(bit coh, int kg, int nkg, int kg_i, int nkg_i);
        acc_pkg::sample_t s;
        acc_pkg::acc_t    ext;
        bit               used;
        bit               first;
        bit               shown;
        used  = coh || (kg_i == kg - 1);
        first = coh ? (kg_i == 0) : (nkg_i == 0);
        shown = coh || ((kg_i == kg - 1) && (nkg_i == nkg - 1));
        for (int i = 0; i < N_ARGS; i++) begin
            s   = acc_pkg::sample_t'($urandom);
            ext = {{(`ACC_OUT_WIDTH - `ACC_IN_WIDTH){s[`ACC_IN_WIDTH-1]}}, s};
            if (used) begin
                model[i] = first ? ext : model[i] + ext;
            end
            we   = 1'b1;
            r_in = s;
            // Result is due two cycles after this we cycle
            if (shown) begin
                exp_cycle.push_back(cycle_no + 2);
                exp_val.push_back(model[i]);
                exp_arg.push_back(i);
            end
            @(posedge clk);
            #10;
        end
        we   = 1'b0;
        r_in = '0;
    endtask

    task automatic do_run(int idx);
        bit coh;
        int kg;
        int nkg;
        coh = run_coh[idx] != 0;
        kg  = run_kg[idx];
        nkg = run_nkg[idx];
        reset     = 1'b1;
        we        = 1'b0;
        coh_mode  = coh;
        kg_count  = acc_pkg::burst_cnt_t'(kg);
        nkg_count = acc_pkg::burst_cnt_t'(nkg);
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int f = 0; f < run_frames[idx]; f++) begin
            for (int g = 0; g < nkg; g++) begin
                for (int b = 0; b < kg; b++) begin
                    drive_burst(coh, kg, nkg, b, g);
                    idle_cycles(`ACC_BURST_GAP + $urandom_range(MAX_JITTER, 0));
                end
            end
        end
        // Wait for the last expected outputs, the watchdog bounds this
        while (exp_cycle.size() != 0) begin
            @(posedge clk);
        end
        #10;
    endtask

    // Outputs are checked at the falling edge, away from any input change
    always @(negedge clk) begin : monitor
        bit exp_now;
        if (armed) begin
            exp_now = (exp_cycle.size() > 0) && (exp_cycle[0] == cycle_no);
            assert (valid === exp_now) else begin
                report_mismatch("valid", longint'(exp_now), longint'(valid));
            end
            if (exp_now) begin
                assert (r_out === exp_val[0]) else begin
                    report_mismatch($sformatf("r_out (arg %0d)", exp_arg[0]),
                                    longint'(exp_val[0]), longint'(r_out));
                end
                void'(exp_cycle.pop_front());
                void'(exp_val.pop_front());
                void'(exp_arg.pop_front());
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = total_bursts() * (N_ARGS + `ACC_BURST_GAP + 4) + N_RUNS * 20 + 50;
        repeat (limit) @(posedge clk);
        abort_run("timeout, the DUT did not deliver all expected outputs");
    end

    initial begin
        void'($urandom(20));
        reset     = 1'b1;
        coh_mode  = 1'b0;
        kg_count  = acc_pkg::burst_cnt_t'(1);
        nkg_count = acc_pkg::burst_cnt_t'(1);
        we        = 1'b0;
        r_in      = '0;
        @(posedge clk);
        armed = 1'b1;
        #10;
        for (int r = 0; r < N_RUNS; r++) begin
            do_run(r);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/acc_pkg.sv
verilog/delay_line.sv
verilog/line_memory.sv
verilog/accum_sequencer.sv
verilog/accum_datapath.sv
verilog/arr_accum.sv
tb/tb_arr_accum.sv

/* Makefile */
# Verilator build for the array accumulator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_arr_accum
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
